// ==== Bender.yml ====
package:
  name: dbg_brk

sources:
  # Packages first, then the RTL, top level last
  - files:
      - logic/dbg_brk_pkg.sv
      - logic/cpu_bus_pkg.sv
      - logic/dbg_hwbrk.sv
      - logic/dbg_brk_trace_fifo.sv
      - logic/dbg_halt_ctl.sv
      - logic/dbg_reg_decoder.sv
      - logic/dbg_brk_top.sv

  # Testbench
  - target: test
    files:
      - tb/dbg_brk_tb.sv

// ==== logic/cpu_bus_pkg.sv ====
/*
  CPU-side bus views seen by the debug unit.
  Execution-unit memory bus and frontend decode information.
*/
package cpu_bus_pkg;

  // CPU address width
  typedef logic [15:0] cpu_addr_t;

  // Execution-unit data bus
  typedef struct packed {
    // Memory address bus
    cpu_addr_t   mab;
    // Memory bus enable
    logic        mb_en;
    // Byte write enables, zero for a read
    logic [1:0]  mb_wr;
  } eu_bus_t;

  // Frontend at instruction decode
  typedef struct packed {
    // Program counter of the decoded instruction
    cpu_addr_t pc;
    // Decode of a real instruction, not an IRQ
    logic      decode_noirq;
  } fe_bus_t;

endpackage

// ==== logic/dbg_brk_pkg.sv ====
/*
  Debug-side definitions for the hardware breakpoint subsystem.
  Host register map, breakpoint control bits, trace record and widths.
*/
package dbg_brk_pkg;

  // Host side widths
  typedef logic [15:0] dbg_data_t;
  typedef logic [3:0]  dbg_reg_addr_t;

  // Breakpoint unit registers
  typedef logic [15:0] brk_addr_t;
  typedef logic [4:0]  brk_ctl_t;
  // Bits 0..5: addr0_rd, addr0_wr, addr1_rd, addr1_wr, range_rd, range_wr
  typedef logic [5:0]  brk_stat_t;
  // One-hot select within a unit
  typedef logic [3:0]  brk_sel_t;

  localparam int unsigned BRK_UNITS = 2;

  // Select bit of each register inside a unit
  localparam int unsigned SEL_CTL   = 0;
  localparam int unsigned SEL_STAT  = 1;
  localparam int unsigned SEL_ADDR0 = 2;
  localparam int unsigned SEL_ADDR1 = 3;

  // CTL bit positions
  localparam int unsigned BRK_MODE_RD = 0;
  localparam int unsigned BRK_MODE_WR = 1;
  localparam int unsigned BRK_EN      = 2;
  localparam int unsigned BRK_I_EN    = 3;
  localparam int unsigned BRK_RANGE   = 4;

  // Range comparator present
  localparam logic HWBRK_RANGE = 1'b1;

  // Trace buffer
  localparam int unsigned TRACE_DEPTH = 4;
  typedef logic [2:0] trace_cnt_t;
  typedef logic [$clog2(TRACE_DEPTH)-1:0] trace_ptr_t;

  typedef struct packed {
    brk_addr_t addr;
    logic      inst;
    brk_stat_t stat0;
    brk_stat_t stat1;
  } trace_rec_t;

  // Host register map
  localparam dbg_reg_addr_t BRK0_BASE  = 4'd0;
  localparam dbg_reg_addr_t BRK1_BASE  = 4'd4;
  localparam dbg_reg_addr_t TRACE_ADDR = 4'd8;
  localparam dbg_reg_addr_t TRACE_INFO = 4'd9;
  localparam dbg_reg_addr_t TRACE_STAT = 4'd10;
  localparam dbg_reg_addr_t CPU_CTL    = 4'd11;

endpackage

// ==== logic/dbg_brk_top.sv ====
/*
  Hardware breakpoint subsystem top.
  Two breakpoint units, the hit trace FIFO, the halt controller
  and the host register decoder.
*/
`timescale 1ns/100ps

module dbg_brk_top
  import dbg_brk_pkg::*, cpu_bus_pkg::*;
(
  input  logic          dbg_clk,
  input  logic          dbg_rst,
  // Host side
  input  dbg_reg_addr_t dbg_addr,
  input  dbg_data_t     dbg_din,
  input  logic          dbg_rd,
  input  logic          dbg_wr,
  output dbg_data_t     dbg_dout,
  // CPU side
  input  eu_bus_t       eu,
  input  fe_bus_t       fe,
  output logic          cpu_halt,
  output logic          brk_pnd
);

  brk_sel_t             brk0_rd;
  brk_sel_t             brk0_wr;
  brk_sel_t             brk1_rd;
  brk_sel_t             brk1_wr;
  dbg_data_t            brk0_dout;
  dbg_data_t            brk1_dout;
  brk_stat_t            stat_set0;
  brk_stat_t            stat_set1;
  logic                 brk_pnd0;
  logic                 brk_pnd1;
  logic                 brk_halt0;
  logic                 brk_halt1;
  trace_rec_t           head;
  trace_cnt_t           count;
  logic                 overflow;
  logic                 trace_pop;
  logic                 ovf_clr;
  logic                 resume;
  logic [BRK_UNITS-1:0] cause;

  ////////////////////
  // Breakpoint units
  ////////////////////

  dbg_hwbrk u_brk0 (
    .dbg_clk, .dbg_rst, .brk_rd(brk0_rd), .brk_wr(brk0_wr), .dbg_din, .eu, .fe,
    .brk_dout(brk0_dout), .stat_set(stat_set0), .brk_pnd(brk_pnd0), .brk_halt(brk_halt0)
  );

  dbg_hwbrk u_brk1 (
    .dbg_clk, .dbg_rst, .brk_rd(brk1_rd), .brk_wr(brk1_wr), .dbg_din, .eu, .fe,
    .brk_dout(brk1_dout), .stat_set(stat_set1), .brk_pnd(brk_pnd1), .brk_halt(brk_halt1)
  );

  assign brk_pnd = brk_pnd0 | brk_pnd1;

  // Hit history
  dbg_brk_trace_fifo u_trace (
    .dbg_clk, .dbg_rst, .stat0(stat_set0), .stat1(stat_set1), .eu, .fe,
    .trace_pop, .ovf_clr, .head, .count, .overflow
  );

  // CPU halt
  dbg_halt_ctl u_halt (
    .dbg_clk, .dbg_rst, .brk_halt0, .brk_halt1, .resume, .cpu_halt, .cause
  );

  // Host registers
  dbg_reg_decoder u_dec (
    .dbg_addr, .dbg_din, .dbg_rd, .dbg_wr, .brk0_dout, .brk1_dout,
    .head, .count, .overflow, .cpu_halt, .cause, .dbg_dout,
    .brk0_rd, .brk0_wr, .brk1_rd, .brk1_wr, .trace_pop, .ovf_clr, .resume
  );

endmodule

// ==== logic/dbg_brk_trace_fifo.sv ====
/*
  Breakpoint hit trace buffer.
  Records each hit cycle from both units into a small circular FIFO,
  flags a sticky overflow when a hit arrives while full.
*/
`timescale 1ns/100ps

module dbg_brk_trace_fifo
  import dbg_brk_pkg::*, cpu_bus_pkg::*;
(
  input  logic       dbg_clk,
  input  logic       dbg_rst,
  input  brk_stat_t  stat0,
  input  brk_stat_t  stat1,
  input  eu_bus_t    eu,
  input  fe_bus_t    fe,
  input  logic       trace_pop,
  input  logic       ovf_clr,
  output trace_rec_t head,
  output trace_cnt_t count,
  output logic       overflow
);

  trace_rec_t mem [TRACE_DEPTH];
  trace_ptr_t wr_ptr;
  trace_ptr_t rd_ptr;
  trace_rec_t rec;
  logic       push;
  logic       pop;
  logic       full;
  logic       push_ok;

  // Record for this cycle
  // With both buses active the data flow is recorded
  assign rec.inst  = fe.decode_noirq & ~eu.mb_en;
  assign rec.addr  = rec.inst ? fe.pc : eu.mab;
  assign rec.stat0 = stat0;
  assign rec.stat1 = stat1;

  assign push    = (|stat0) | (|stat1);
  assign pop     = trace_pop & (count != '0);
  assign full    = (count == trace_cnt_t'(TRACE_DEPTH));
  // A pop in the same cycle frees a slot
  assign push_ok = push & (~full | pop);

  // Storage
  always_ff @(posedge dbg_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= rec;
    end
  end

  // Pointers and fill level
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_ok && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push_ok) begin
        count <= count - 1'b1;
      end
    end
  end

  // Sticky overflow, a drop in the clear cycle keeps it set
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      overflow <= 1'b0;
    end else if (push && !push_ok) begin
      overflow <= 1'b1;
    end else if (ovf_clr) begin
      overflow <= 1'b0;
    end
  end

  assign head = mem[rd_ptr];

endmodule

// ==== logic/dbg_halt_ctl.sv ====
/*
  CPU halt controller.
  Latches halt requests from the breakpoint units with their cause
  and releases the CPU on a host resume.
*/
`timescale 1ns/100ps

module dbg_halt_ctl
  import dbg_brk_pkg::*;
(
  input  logic                 dbg_clk,
  input  logic                 dbg_rst,
  input  logic                 brk_halt0,
  input  logic                 brk_halt1,
  input  logic                 resume,
  output logic                 cpu_halt,
  output logic [BRK_UNITS-1:0] cause
);

  typedef enum logic {
    HALT_RUN,
    HALT_STOP
  } halt_state_t;

  halt_state_t          state;
  halt_state_t          state_nxt;
  logic [BRK_UNITS-1:0] req;

  // Bit n set when unit n requests a halt
  assign req = {brk_halt1, brk_halt0};

  // New request beats a resume in the same cycle
  always_comb begin
    state_nxt = state;
    if (|req) begin
      state_nxt = HALT_STOP;
    end else if (resume) begin
      state_nxt = HALT_RUN;
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state <= HALT_RUN;
      cause <= '0;
    end else begin
      state <= state_nxt;
      // Resume drops old causes, new requests still land
      cause <= (resume ? '0 : cause) | req;
    end
  end

  assign cpu_halt = (state == HALT_STOP);

endmodule

// ==== logic/dbg_hwbrk.sv ====
/*
  Hardware breakpoint / watchpoint unit.
  Holds CTL, STAT, ADDR0 and ADDR1, compares the data or instruction
  address against them and raises sticky hit flags and a halt request.
*/
`timescale 1ns/100ps

module dbg_hwbrk
  import dbg_brk_pkg::*, cpu_bus_pkg::*;
(
  input  logic      dbg_clk,
  input  logic      dbg_rst,
  input  brk_sel_t  brk_rd,
  input  brk_sel_t  brk_wr,
  input  dbg_data_t dbg_din,
  input  eu_bus_t   eu,
  input  fe_bus_t   fe,
  output dbg_data_t brk_dout,
  output brk_stat_t stat_set,
  output logic      brk_pnd,
  output logic      brk_halt
);

  brk_ctl_t  brk_ctl;
  brk_stat_t brk_stat;
  brk_addr_t brk_addr0;
  brk_addr_t brk_addr1;

  // Comparator inputs
  brk_addr_t src_addr;
  logic      src_vld;
  logic      src_wr;
  logic      range_mode;
  logic      hit_addr0;
  logic      hit_addr1;
  logic      hit_range;

  ////////////////////
  // Registers
  ////////////////////

  // CTL, range bit only kept when range support is built in
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      brk_ctl <= '0;
    end else if (brk_wr[SEL_CTL]) begin
      brk_ctl <= {HWBRK_RANGE & dbg_din[BRK_RANGE], dbg_din[BRK_I_EN:BRK_MODE_RD]};
    end
  end

  // STAT, sticky flags
  // Write keeps flags whose data bit is 1, new hits always win
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      brk_stat <= '0;
    end else if (brk_wr[SEL_STAT]) begin
      brk_stat <= (brk_stat & dbg_din[5:0]) | stat_set;
    end else begin
      brk_stat <= brk_stat | stat_set;
    end
  end

  // Address registers
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      brk_addr0 <= '0;
      brk_addr1 <= '0;
    end else begin
      if (brk_wr[SEL_ADDR0]) begin
        brk_addr0 <= dbg_din;
      end
      if (brk_wr[SEL_ADDR1]) begin
        brk_addr1 <= dbg_din;
      end
    end
  end

  ////////////////////
  // Read data
  ////////////////////

  // Zero when this unit is not selected
  always_comb begin
    brk_dout = '0;
    if (brk_rd[SEL_CTL]) begin
      brk_dout = brk_dout | dbg_data_t'(brk_ctl);
    end
    if (brk_rd[SEL_STAT]) begin
      brk_dout = brk_dout | dbg_data_t'(brk_stat);
    end
    if (brk_rd[SEL_ADDR0]) begin
      brk_dout = brk_dout | brk_addr0;
    end
    if (brk_rd[SEL_ADDR1]) begin
      brk_dout = brk_dout | brk_addr1;
    end
  end

  ////////////////////
  // Comparators
  ////////////////////

  // Instruction flow when I_EN is set, data flow otherwise
  assign src_addr   = brk_ctl[BRK_I_EN] ? fe.pc : eu.mab;
  assign src_vld    = brk_ctl[BRK_I_EN] ? fe.decode_noirq : eu.mb_en;
  // Instruction fetches only count as reads
  assign src_wr     = ~brk_ctl[BRK_I_EN] & (|eu.mb_wr);
  assign range_mode = HWBRK_RANGE & brk_ctl[BRK_RANGE];

  assign hit_addr0 = src_vld & ~range_mode & (src_addr == brk_addr0);
  assign hit_addr1 = src_vld & ~range_mode & (src_addr == brk_addr1);
  assign hit_range = src_vld & range_mode &
                     (src_addr >= brk_addr0) & (src_addr <= brk_addr1);

  // Flags allowed by the access mode bits
  always_comb begin
    stat_set    = '0;
    stat_set[0] = brk_ctl[BRK_MODE_RD] & hit_addr0 & ~src_wr;
    stat_set[1] = brk_ctl[BRK_MODE_WR] & hit_addr0 & src_wr;
    stat_set[2] = brk_ctl[BRK_MODE_RD] & hit_addr1 & ~src_wr;
    stat_set[3] = brk_ctl[BRK_MODE_WR] & hit_addr1 & src_wr;
    stat_set[4] = brk_ctl[BRK_MODE_RD] & hit_range & ~src_wr;
    stat_set[5] = brk_ctl[BRK_MODE_WR] & hit_range & src_wr;
  end

  // Pending while any flag is up
  assign brk_pnd  = |brk_stat;
  // Halt request in the hit cycle when break mode is on
  assign brk_halt = brk_ctl[BRK_EN] & (|stat_set);

endmodule

// ==== logic/dbg_reg_decoder.sv ====
/*
  Debug host register decoder.
  Maps host addresses onto unit selects and side-effect strobes
  and multiplexes the read data.
*/
`timescale 1ns/100ps

module dbg_reg_decoder
  import dbg_brk_pkg::*;
(
  input  dbg_reg_addr_t        dbg_addr,
  input  dbg_data_t            dbg_din,
  input  logic                 dbg_rd,
  input  logic                 dbg_wr,
  input  dbg_data_t            brk0_dout,
  input  dbg_data_t            brk1_dout,
  input  trace_rec_t           head,
  input  trace_cnt_t           count,
  input  logic                 overflow,
  input  logic                 cpu_halt,
  input  logic [BRK_UNITS-1:0] cause,
  output dbg_data_t            dbg_dout,
  output brk_sel_t             brk0_rd,
  output brk_sel_t             brk0_wr,
  output brk_sel_t             brk1_rd,
  output brk_sel_t             brk1_wr,
  output logic                 trace_pop,
  output logic                 ovf_clr,
  output logic                 resume
);

  logic     in_brk0;
  logic     in_brk1;
  logic     trace_vld;
  brk_sel_t reg_sel;

  ////////////////////
  // Address decode
  ////////////////////

  // Each unit owns an aligned block of four registers
  assign in_brk0 = (dbg_addr[3:2] == BRK0_BASE[3:2]);
  assign in_brk1 = (dbg_addr[3:2] == BRK1_BASE[3:2]);
  assign reg_sel = brk_sel_t'(1) << dbg_addr[1:0];

  assign brk0_rd = (in_brk0 & dbg_rd) ? reg_sel : '0;
  assign brk0_wr = (in_brk0 & dbg_wr) ? reg_sel : '0;
  assign brk1_rd = (in_brk1 & dbg_rd) ? reg_sel : '0;
  assign brk1_wr = (in_brk1 & dbg_wr) ? reg_sel : '0;

  // Side-effect strobes
  assign trace_vld = (count != '0);
  assign trace_pop = dbg_rd & (dbg_addr == TRACE_INFO) & trace_vld;
  assign ovf_clr   = dbg_wr & (dbg_addr == TRACE_STAT) & dbg_din[0];
  assign resume    = dbg_wr & (dbg_addr == CPU_CTL) & dbg_din[0];

  ////////////////////
  // Read mux
  ////////////////////

  always_comb begin
    dbg_dout = '0;
    if (dbg_rd) begin
      case (dbg_addr)
        TRACE_ADDR: begin
          dbg_dout = trace_vld ? head.addr : '0;
        end
        // stat0 in 5:0, stat1 in 11:6, inst in 12
        TRACE_INFO: begin
          dbg_dout = trace_vld ? dbg_data_t'({head.inst, head.stat1, head.stat0}) : '0;
        end
        TRACE_STAT: dbg_dout = dbg_data_t'({overflow, count});
        CPU_CTL:    dbg_dout = dbg_data_t'({cause, cpu_halt});
        // Units return zero unless selected
        default:    dbg_dout = brk0_dout | brk1_dout;
      endcase
    end
  end

endmodule

// ==== tb/dbg_brk_tb.sv ====
/*
  Testbench for the hardware breakpoint subsystem.
  Drives host accesses and CPU bus cycles, keeps a reference model
  of every register, the trace FIFO and the halt state, and compares.
*/
`timescale 1ns/100ps

module dbg_brk_tb
  import dbg_brk_pkg::*, cpu_bus_pkg::*;
();

  localparam int          CLK_PERIOD      = 20;
  localparam int          NUM_TESTS       = 6;
  localparam int          WATCHDOG_CYCLES = NUM_TESTS * 200;
  localparam logic [31:0] LFSR_SEED       = 32'ha98e;

  // CTL values
  localparam dbg_data_t C_RD    = dbg_data_t'(1 << BRK_MODE_RD);
  localparam dbg_data_t C_WR    = dbg_data_t'(1 << BRK_MODE_WR);
  localparam dbg_data_t C_EN    = dbg_data_t'(1 << BRK_EN);
  localparam dbg_data_t C_IEN   = dbg_data_t'(1 << BRK_I_EN);
  localparam dbg_data_t C_RANGE = dbg_data_t'(1 << BRK_RANGE);

  localparam eu_bus_t EU_IDLE = '0;
  localparam fe_bus_t FE_IDLE = '0;

  logic          dbg_clk;
  logic          dbg_rst;
  dbg_reg_addr_t dbg_addr;
  dbg_data_t     dbg_din;
  logic          dbg_rd;
  logic          dbg_wr;
  dbg_data_t     dbg_dout;
  eu_bus_t       eu;
  fe_bus_t       fe;
  logic          cpu_halt;
  logic          brk_pnd;

  // Reference state
  brk_ctl_t             sh_ctl   [BRK_UNITS];
  brk_stat_t            sh_stat  [BRK_UNITS];
  brk_addr_t            sh_addr0 [BRK_UNITS];
  brk_addr_t            sh_addr1 [BRK_UNITS];
  trace_rec_t           sh_trace [$];
  logic                 sh_ovf;
  logic                 sh_halted;
  logic [BRK_UNITS-1:0] sh_cause;

  logic [31:0] lfsr_state;
  logic        chk_en;
  dbg_data_t   exp_dout;

  dbg_brk_top DUT (
    .dbg_clk, .dbg_rst, .dbg_addr, .dbg_din, .dbg_rd, .dbg_wr, .dbg_dout,
    .eu, .fe, .cpu_halt, .brk_pnd
  );

  ////////////////////
  // Clock and watchdog
  ////////////////////

  initial begin
    dbg_clk = 1'b0;
    forever #(CLK_PERIOD / 2) dbg_clk = ~dbg_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $fatal(1);
  end

  ////////////////////
  // Reference model
  ////////////////////

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  // One step per bit taken
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] val;
    logic        fb;
    int unsigned i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  // Returns the expected read data and moves the state past the next edge
  function automatic dbg_data_t model_step(dbg_reg_addr_t addr, dbg_data_t din, logic rd,
                                           logic wr, eu_bus_t e, fe_bus_t f);
    brk_stat_t            hits [BRK_UNITS];
    brk_addr_t            src;
    logic                 vld;
    logic                 is_wr;
    logic                 ranged;
    logic [BRK_UNITS-1:0] req;
    logic                 from_fe;
    logic                 do_pop;
    logic                 drop;
    int                   fill;
    trace_rec_t           rec;
    dbg_data_t            rdata;
    int                   u;
    from_fe = 1'b0;
    // Hits use the register contents before the edge
    for (u = 0; u < BRK_UNITS; u++) begin
      src    = sh_ctl[u][BRK_I_EN] ? f.pc : e.mab;
      vld    = sh_ctl[u][BRK_I_EN] ? f.decode_noirq : e.mb_en;
      is_wr  = !sh_ctl[u][BRK_I_EN] && (e.mb_wr != 2'b00);
      ranged = HWBRK_RANGE && sh_ctl[u][BRK_RANGE];
      hits[u] = '0;
      if (vld && !ranged && src == sh_addr0[u]) hits[u][is_wr ? 1 : 0] = 1'b1;
      if (vld && !ranged && src == sh_addr1[u]) hits[u][is_wr ? 3 : 2] = 1'b1;
      if (vld && ranged && src >= sh_addr0[u] && src <= sh_addr1[u]) begin
        hits[u][is_wr ? 5 : 4] = 1'b1;
      end
      // Even bits are read flags and odd bits write flags
      if (!sh_ctl[u][BRK_MODE_RD]) hits[u] &= 6'b101010;
      if (!sh_ctl[u][BRK_MODE_WR]) hits[u] &= 6'b010101;
      req[u] = sh_ctl[u][BRK_EN] && (hits[u] != '0);
      // Hit carried by the instruction flow
      if (sh_ctl[u][BRK_I_EN] && hits[u] != '0) from_fe = 1'b1;
    end
    fill  = sh_trace.size();
    rdata = '0;
    if (rd) begin
      if (addr < TRACE_ADDR) begin
        case (addr[1:0])
          2'd0: rdata = dbg_data_t'(sh_ctl[addr[2]]);
          2'd1: rdata = dbg_data_t'(sh_stat[addr[2]]);
          2'd2: rdata = sh_addr0[addr[2]];
          2'd3: rdata = sh_addr1[addr[2]];
        endcase
      end else if (addr == TRACE_ADDR && fill != 0) begin
        rdata = sh_trace[0].addr;
      end else if (addr == TRACE_INFO && fill != 0) begin
        rdata = dbg_data_t'({sh_trace[0].inst, sh_trace[0].stat1, sh_trace[0].stat0});
      end else if (addr == TRACE_STAT) begin
        rdata = dbg_data_t'({sh_ovf, trace_cnt_t'(fill)});
      end else if (addr == CPU_CTL) begin
        rdata = dbg_data_t'({sh_cause, sh_halted});
      end
    end
    // Host writes into the units
    // New hits win over a STAT clear
    for (u = 0; u < BRK_UNITS; u++) begin
      if (wr && addr < TRACE_ADDR && int'(addr[2]) == u) begin
        case (addr[1:0])
          2'd0: sh_ctl[u] = {HWBRK_RANGE & din[BRK_RANGE], din[3:0]};
          2'd1: sh_stat[u] = sh_stat[u] & din[5:0];
          2'd2: sh_addr0[u] = din;
          2'd3: sh_addr1[u] = din;
        endcase
      end
      sh_stat[u] = sh_stat[u] | hits[u];
    end
    // Trace FIFO where a pop and a push in one cycle both happen
    do_pop = rd && addr == TRACE_INFO && fill != 0;
    drop   = 1'b0;
    if (do_pop) void'(sh_trace.pop_front());
    if (hits[0] != '0 || hits[1] != '0) begin
      rec.inst  = from_fe;
      rec.addr  = from_fe ? f.pc : e.mab;
      rec.stat0 = hits[0];
      rec.stat1 = hits[1];
      if (fill < TRACE_DEPTH || do_pop) sh_trace.push_back(rec);
      else drop = 1'b1;
    end
    if (drop) sh_ovf = 1'b1;
    else if (wr && addr == TRACE_STAT && din[0]) sh_ovf = 1'b0;
    // Halt latch where a request beats a resume
    if (wr && addr == CPU_CTL && din[0]) begin
      sh_cause = '0;
      if (req == '0) sh_halted = 1'b0;
    end
    if (req != '0) sh_halted = 1'b1;
    sh_cause = sh_cause | req;
    return rdata;
  endfunction

  function automatic string reg_name(dbg_reg_addr_t addr, logic rd);
    string regs [4] = '{"CTL", "STAT", "ADDR0", "ADDR1"};
    if (!rd) return "idle dbg_dout";
    if (addr < TRACE_ADDR) return $sformatf("BRK%0d_%s", addr[2], regs[addr[1:0]]);
    case (addr)
      TRACE_ADDR: return "TRACE_ADDR";
      TRACE_INFO: return "TRACE_INFO";
      TRACE_STAT: return "TRACE_STAT";
      CPU_CTL:    return "CPU_CTL";
      default:    return $sformatf("unmapped 0x%0h", addr);
    endcase
  endfunction

  ////////////////////
  // Compare
  ////////////////////

  task automatic check_data(string name, dbg_data_t got, dbg_data_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s read 0x%04h, expected 0x%04h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_halt(logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: cpu_halt is %b, expected %b", $time, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_pnd(logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: brk_pnd is %b, expected %b", $time, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Sample mid low phase with inputs settled
  always begin
    @(negedge dbg_clk);
    #(CLK_PERIOD / 4);
    if (chk_en) begin
      check_halt(cpu_halt, sh_halted);
      check_pnd(brk_pnd, (sh_stat[0] != '0) || (sh_stat[1] != '0));
      exp_dout = model_step(dbg_addr, dbg_din, dbg_rd, dbg_wr, eu, fe);
      check_data(reg_name(dbg_addr, dbg_rd), dbg_dout, exp_dout);
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // One cycle of inputs applied on the falling edge
  task automatic drive(dbg_reg_addr_t a, dbg_data_t d, logic rd, logic wr,
                       eu_bus_t e, fe_bus_t f);
    @(negedge dbg_clk);
    dbg_addr = a;
    dbg_din  = d;
    dbg_rd   = rd;
    dbg_wr   = wr;
    eu       = e;
    fe       = f;
  endtask

  function automatic eu_bus_t eu_access(brk_addr_t a, logic w);
    return '{mab: a, mb_en: 1'b1, mb_wr: (w ? 2'b11 : 2'b00)};
  endfunction

  function automatic dbg_reg_addr_t brk_reg(int unsigned unit, int unsigned sel);
    return (unit == 0 ? BRK0_BASE : BRK1_BASE) + dbg_reg_addr_t'(sel);
  endfunction

  task automatic host_write(dbg_reg_addr_t a, dbg_data_t d);
    drive(a, d, 1'b0, 1'b1, EU_IDLE, FE_IDLE);
  endtask

  task automatic host_read(dbg_reg_addr_t a);
    drive(a, '0, 1'b1, 1'b0, EU_IDLE, FE_IDLE);
  endtask

  task automatic data_access(brk_addr_t a, logic w);
    drive('0, '0, 1'b0, 1'b0, eu_access(a, w), FE_IDLE);
  endtask

  task automatic setup_unit(int unsigned unit, dbg_data_t ctl, brk_addr_t a0, brk_addr_t a1);
    host_write(brk_reg(unit, SEL_ADDR0), a0);
    host_write(brk_reg(unit, SEL_ADDR1), a1);
    host_write(brk_reg(unit, SEL_CTL), ctl);
  endtask

  task automatic read_stats();
    host_read(brk_reg(0, SEL_STAT));
    host_read(brk_reg(1, SEL_STAT));
  endtask

  // Clear flags and empty the trace between tests
  task automatic clean_up();
    read_stats();
    host_write(brk_reg(0, SEL_STAT), '0);
    host_write(brk_reg(1, SEL_STAT), '0);
    repeat (TRACE_DEPTH) host_read(TRACE_INFO);
    host_write(TRACE_STAT, 16'h0001);
    host_read(TRACE_STAT);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_registers();
    setup_unit(0, 16'hffff, 16'h1111, 16'h2222);
    setup_unit(1, C_RANGE | C_EN | C_RD, 16'h3333, 16'h4444);
    for (int a = 0; a < 16; a++) host_read(dbg_reg_addr_t'(a));
    host_write(brk_reg(0, SEL_CTL), '0);
    host_write(brk_reg(1, SEL_CTL), '0);
    host_read(brk_reg(0, SEL_CTL));
  endtask

  task automatic test_data_hits();
    setup_unit(0, C_RD | C_WR, 16'h1200, 16'h1202);
    setup_unit(1, C_WR, 16'h1204, 16'h1201);
    for (int i = 0; i < 40; i++) begin
      data_access(16'h1200 + brk_addr_t'(rand_bits(3)), 1'(rand_bits(1)));
      if (i % 8 == 7) clean_up();
    end
    clean_up();
  endtask

  task automatic test_inst_range();
    fe_bus_t f;
    eu_bus_t e;
    setup_unit(0, C_IEN | C_RANGE | C_RD | C_WR, 16'hc000, 16'hc010);
    setup_unit(1, C_IEN | C_RD | C_WR, 16'hc004, 16'hc020);
    for (int i = 0; i < 30; i++) begin
      f.pc           = 16'hbff8 + brk_addr_t'(rand_bits(6));
      f.decode_noirq = 1'(rand_bits(1));
      // Write enables without a data access leave instruction hits as reads
      e.mab          = '0;
      e.mb_en        = 1'b0;
      e.mb_wr        = 2'(rand_bits(2));
      drive('0, '0, 1'b0, 1'b0, e, f);
      if (i % 6 == 5) clean_up();
    end
    clean_up();
  endtask

  task automatic test_stat_clear();
    setup_unit(0, C_RD | C_WR, 16'h2000, 16'h2002);
    setup_unit(1, '0, '0, '0);
    data_access(16'h2000, 1'b0);
    data_access(16'h2000, 1'b1);
    data_access(16'h2002, 1'b0);
    data_access(16'h2002, 1'b1);
    read_stats();
    // Clear addr0_wr and addr1_wr while addr1_wr hits again
    drive(brk_reg(0, SEL_STAT), 16'h0005, 1'b0, 1'b1, eu_access(16'h2002, 1'b1), FE_IDLE);
    read_stats();
    clean_up();
  endtask

  task automatic test_halt();
    setup_unit(0, '0, '0, '0);
    setup_unit(1, C_EN | C_RD, 16'h3000, 16'h3000);
    host_read(CPU_CTL);
    data_access(16'h3000, 1'b0);
    host_read(CPU_CTL);
    host_write(CPU_CTL, 16'h0001);
    host_read(CPU_CTL);
    // Hit together with resume keeps the CPU halted
    data_access(16'h3000, 1'b0);
    drive(CPU_CTL, 16'h0001, 1'b0, 1'b1, eu_access(16'h3000, 1'b0), FE_IDLE);
    host_read(CPU_CTL);
    host_write(CPU_CTL, 16'h0001);
    host_read(CPU_CTL);
    setup_unit(1, '0, '0, '0);
    clean_up();
  endtask

  task automatic test_trace();
    setup_unit(0, C_RD | C_WR, 16'h4000, 16'h4002);
    data_access(16'h4000, 1'b0);
    data_access(16'h4002, 1'b1);
    data_access(16'h4000, 1'b1);
    host_read(TRACE_STAT);
    repeat (3) begin
      host_read(TRACE_ADDR);
      host_read(TRACE_INFO);
    end
    host_read(TRACE_STAT);
    // Six unread hits into four entries
    for (int i = 0; i < 6; i++) data_access(16'h4000 + brk_addr_t'(2 * (i % 2)), i % 3 == 0);
    host_read(TRACE_STAT);
    host_write(TRACE_STAT, 16'h0001);
    host_read(TRACE_STAT);
    repeat (TRACE_DEPTH) begin
      host_read(TRACE_ADDR);
      host_read(TRACE_INFO);
    end
    clean_up();
  endtask

  initial begin
    lfsr_state = LFSR_SEED;
    chk_en     = 1'b0;
    dbg_rst    = 1'b1;
    dbg_addr   = '0;
    dbg_din    = '0;
    dbg_rd     = 1'b0;
    dbg_wr     = 1'b0;
    eu         = EU_IDLE;
    fe         = FE_IDLE;
    sh_ctl     = '{default: '0};
    sh_stat    = '{default: '0};
    sh_addr0   = '{default: '0};
    sh_addr1   = '{default: '0};
    sh_ovf     = 1'b0;
    sh_halted  = 1'b0;
    sh_cause   = '0;
    repeat (16) @(posedge dbg_clk);
    @(negedge dbg_clk);
    dbg_rst = 1'b0;
    chk_en  = 1'b1;
    test_registers();
    test_data_hits();
    test_inst_range();
    test_stat_clear();
    test_halt();
    test_trace();
    repeat (4) drive('0, '0, 1'b0, 1'b0, EU_IDLE, FE_IDLE);
    @(negedge dbg_clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/dbg_brk_pkg.sv
logic/cpu_bus_pkg.sv
logic/dbg_hwbrk.sv
logic/dbg_brk_trace_fifo.sv
logic/dbg_halt_ctl.sv
logic/dbg_reg_decoder.sv
logic/dbg_brk_top.sv
tb/dbg_brk_tb.sv
